//--- design/age_selector.sv
module age_selector
    import store_iq_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_i,
    input  logic [ENTRY_W-1:0]   alloc_entry_i,
    input  logic [BANK_SIZE-1:0] ready_i,
    output logic                 select_valid_o,
    output logic [ENTRY_W-1:0]   select_entry_o
);

    // older_q[i][j] is set when entry i is older than entry j
    logic [BANK_SIZE-1:0][BANK_SIZE-1:0] older_q;
    logic [BANK_SIZE-1:0][BANK_SIZE-1:0] older_col;
    logic [BANK_SIZE-1:0]                grant;

    // The new entry becomes younger than everything already resident.
    // Clearing the row last also keeps the diagonal at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            older_q <= '0;
        end else if (alloc_i) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                older_q[i][alloc_entry_i] <= 1'b1;
            end
            older_q[alloc_entry_i] <= '0;
        end
    end

    // ----------------------------------------
    // Oldest ready pick
    // ----------------------------------------

    generate
        for (genvar i = 0; i < BANK_SIZE; i++) begin : g_col
            for (genvar j = 0; j < BANK_SIZE; j++) begin : g_row
                assign older_col[i][j] = older_q[j][i];
            end
            // Stale bits of free entries are masked by ready_i
            assign grant[i] = ready_i[i] & ~|(ready_i & older_col[i]);
        end
    endgenerate

    assign select_valid_o = |ready_i;

    always_comb begin
        select_entry_o = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            if (grant[i]) begin
                select_entry_o = ENTRY_W'(i);
            end
        end
    end

endmodule

//--- design/store_addr_bank.sv
module store_addr_bank
    import store_iq_cfg_pkg::*;
    import store_iq_types_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                alloc_i,
    input  rob_idx_t                            alloc_rob_idx_i,
    input  logic [SQ_W-1:0]                     alloc_sq_idx_i,
    input  size_code_t                          alloc_size_i,
    input  logic [IMM_W-1:0]                    alloc_imm_i,
    input  logic [PREG_W-1:0]                   alloc_rs1_i,
    input  logic                                alloc_rs1_ready_i,
    input  logic [WAKEUP_PORTS-1:0]             wakeup_en_i,
    input  logic [WAKEUP_PORTS-1:0][PREG_W-1:0] wakeup_preg_i,
    input  logic                                redirect_i,
    input  rob_idx_t                            redirect_rob_idx_i,
    input  logic                                success_i,
    input  logic [ENTRY_W-1:0]                  success_entry_i,
    input  logic                                replay_i,
    input  logic [ENTRY_W-1:0]                  replay_entry_i,
    output logic                                full_o,
    output logic                                issue_o,
    output logic [ENTRY_W-1:0]                  issue_entry_o,
    output logic [PREG_W-1:0]                   issue_rs1_o,
    output logic [IMM_W-1:0]                    issue_imm_o,
    output size_code_t                          issue_size_o,
    output logic [SQ_W-1:0]                     issue_sq_idx_o,
    output rob_idx_t                            issue_rob_idx_o
);

    logic [BANK_SIZE-1:0] valid_q;
    logic [BANK_SIZE-1:0] rs1_valid_q;
    entry_state_e         state_q [BANK_SIZE];

    rob_idx_t             rob_idx_q [BANK_SIZE];
    logic [SQ_W-1:0]      sq_idx_q  [BANK_SIZE];
    size_code_t           size_q    [BANK_SIZE];
    logic [IMM_W-1:0]     imm_q     [BANK_SIZE];
    logic [PREG_W-1:0]    rs1_q     [BANK_SIZE];

    logic [ENTRY_W-1:0]   free_entry;
    logic                 alloc_fire;
    logic                 alloc_woken;
    logic [BANK_SIZE-1:0] ready;
    logic                 select_valid;
    logic [ENTRY_W-1:0]   select_entry;
    logic                 issue_fire;

    assign full_o      = &valid_q;
    // A store arriving with the redirect is younger than it and is dropped
    assign alloc_fire  = alloc_i & ~full_o & ~redirect_i;
    assign alloc_woken = preg_woken(wakeup_en_i, wakeup_preg_i, alloc_rs1_i);
    assign issue_fire  = select_valid & ~redirect_i;

    always_comb begin
        free_entry = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_entry = ENTRY_W'(i);
            end
        end
    end

    generate
        for (genvar i = 0; i < BANK_SIZE; i++) begin : g_ready
            assign ready[i] = valid_q[i] & rs1_valid_q[i] & (state_q[i] == ENTRY_WAIT);
        end
    endgenerate

    age_selector u_age_selector (
        .clk            (clk),
        .rst            (rst),
        .alloc_i        (alloc_fire),
        .alloc_entry_i  (free_entry),
        .ready_i        (ready),
        .select_valid_o (select_valid),
        .select_entry_o (select_entry)
    );

    // ----------------------------------------
    // Entry control
    // ----------------------------------------

    // An issued entry stays resident until the memory pipe reports success
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            rs1_valid_q <= '0;
            issue_o     <= 1'b0;
            for (int i = 0; i < BANK_SIZE; i++) begin
                state_q[i] <= ENTRY_WAIT;
            end
        end else begin
            issue_o <= issue_fire;
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (alloc_fire && (free_entry == ENTRY_W'(i))) begin
                    valid_q[i]     <= 1'b1;
                    state_q[i]     <= ENTRY_WAIT;
                    rs1_valid_q[i] <= alloc_rs1_ready_i | alloc_woken;
                end else begin
                    if ((redirect_i && !rob_older(rob_idx_q[i], redirect_rob_idx_i)) ||
                        (success_i && (success_entry_i == ENTRY_W'(i)))) begin
                        valid_q[i] <= 1'b0;
                    end
                    if (issue_fire && (select_entry == ENTRY_W'(i))) begin
                        state_q[i] <= ENTRY_ISSUED;
                    end else if (replay_i && (replay_entry_i == ENTRY_W'(i))) begin
                        state_q[i] <= ENTRY_WAIT;
                    end
                    if (preg_woken(wakeup_en_i, wakeup_preg_i, rs1_q[i])) begin
                        rs1_valid_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Payload and issue register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rob_idx_q[free_entry] <= alloc_rob_idx_i;
            sq_idx_q[free_entry]  <= alloc_sq_idx_i;
            size_q[free_entry]    <= alloc_size_i;
            imm_q[free_entry]     <= alloc_imm_i;
            rs1_q[free_entry]     <= alloc_rs1_i;
        end
        if (issue_fire) begin
            issue_entry_o   <= select_entry;
            issue_rs1_o     <= rs1_q[select_entry];
            issue_imm_o     <= imm_q[select_entry];
            issue_size_o    <= size_q[select_entry];
            issue_sq_idx_o  <= sq_idx_q[select_entry];
            issue_rob_idx_o <= rob_idx_q[select_entry];
        end
    end

endmodule

//--- design/store_data_bank.sv
module store_data_bank
    import store_iq_cfg_pkg::*;
    import store_iq_types_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                alloc_i,
    input  rob_idx_t                            alloc_rob_idx_i,
    input  logic [SQ_W-1:0]                     alloc_sq_idx_i,
    input  size_code_t                          alloc_size_i,
    input  logic [PREG_W-1:0]                   alloc_rs2_i,
    input  logic                                alloc_rs2_ready_i,
    input  logic [WAKEUP_PORTS-1:0]             wakeup_en_i,
    input  logic [WAKEUP_PORTS-1:0][PREG_W-1:0] wakeup_preg_i,
    input  logic                                redirect_i,
    input  rob_idx_t                            redirect_rob_idx_i,
    output logic                                full_o,
    output logic                                issue_o,
    output logic [PREG_W-1:0]                   issue_rs2_o,
    output logic [SQ_W-1:0]                     issue_sq_idx_o,
    output size_code_t                          issue_size_o
);

    logic [BANK_SIZE-1:0] valid_q;
    logic [BANK_SIZE-1:0] rs2_valid_q;

    rob_idx_t             rob_idx_q [BANK_SIZE];
    logic [SQ_W-1:0]      sq_idx_q  [BANK_SIZE];
    size_code_t           size_q    [BANK_SIZE];
    logic [PREG_W-1:0]    rs2_q     [BANK_SIZE];

    logic [ENTRY_W-1:0]   free_entry;
    logic                 alloc_fire;
    logic                 alloc_woken;
    logic                 select_valid;
    logic [ENTRY_W-1:0]   select_entry;
    logic                 issue_fire;

    assign full_o      = &valid_q;
    assign alloc_fire  = alloc_i & ~full_o & ~redirect_i;
    assign alloc_woken = preg_woken(wakeup_en_i, wakeup_preg_i, alloc_rs2_i);
    assign issue_fire  = select_valid & ~redirect_i;

    always_comb begin
        free_entry = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_entry = ENTRY_W'(i);
            end
        end
    end

    // A resident entry is ready once its operand is valid
    age_selector u_age_selector (
        .clk            (clk),
        .rst            (rst),
        .alloc_i        (alloc_fire),
        .alloc_entry_i  (free_entry),
        .ready_i        (valid_q & rs2_valid_q),
        .select_valid_o (select_valid),
        .select_entry_o (select_entry)
    );

    // ----------------------------------------
    // Entry control
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            rs2_valid_q <= '0;
            issue_o     <= 1'b0;
        end else begin
            issue_o <= issue_fire;
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (alloc_fire && (free_entry == ENTRY_W'(i))) begin
                    valid_q[i]     <= 1'b1;
                    rs2_valid_q[i] <= alloc_rs2_ready_i | alloc_woken;
                end else begin
                    // The data half leaves the queue as soon as it issues
                    if ((redirect_i && !rob_older(rob_idx_q[i], redirect_rob_idx_i)) ||
                        (issue_fire && (select_entry == ENTRY_W'(i)))) begin
                        valid_q[i] <= 1'b0;
                    end
                    if (preg_woken(wakeup_en_i, wakeup_preg_i, rs2_q[i])) begin
                        rs2_valid_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rob_idx_q[free_entry] <= alloc_rob_idx_i;
            sq_idx_q[free_entry]  <= alloc_sq_idx_i;
            size_q[free_entry]    <= alloc_size_i;
            rs2_q[free_entry]     <= alloc_rs2_i;
        end
        if (issue_fire) begin
            issue_rs2_o    <= rs2_q[select_entry];
            issue_sq_idx_o <= sq_idx_q[select_entry];
            issue_size_o   <= size_q[select_entry];
        end
    end

endmodule

//--- design/store_iq_cfg_pkg.sv
package store_iq_cfg_pkg;

    // ----------------------------------------
    // Queue geometry
    // ----------------------------------------

    // Entries in each of the address and data banks
    localparam int BANK_SIZE = 8;
    localparam int ENTRY_W   = 3;

    // ----------------------------------------
    // Register file and wakeup
    // ----------------------------------------

    localparam int PREG_W       = 6;
    localparam int WAKEUP_PORTS = 2;

    // ----------------------------------------
    // Pipeline bookkeeping
    // ----------------------------------------

    // Reorder-buffer position without the wrap bit
    localparam int ROB_W = 5;
    localparam int SQ_W  = 4;
    localparam int IMM_W = 12;

endpackage

//--- design/store_iq_types_pkg.sv
package store_iq_types_pkg;
    import store_iq_cfg_pkg::*;

    typedef struct packed {
        logic             wrap;
        logic [ROB_W-1:0] pos;
    } rob_idx_t;

    typedef enum logic [1:0] {
        MEM_SB = 2'd0,
        MEM_SH = 2'd1,
        MEM_SW = 2'd2
    } mem_op_e;

    typedef logic [1:0] size_code_t;

    localparam size_code_t SIZE_BYTE = 2'd0;
    localparam size_code_t SIZE_HALF = 2'd1;
    localparam size_code_t SIZE_WORD = 2'd2;

    typedef enum logic {
        ENTRY_WAIT   = 1'b0,
        ENTRY_ISSUED = 1'b1
    } entry_state_e;

    // True when the entry is strictly older than the redirect point
    function automatic logic rob_older(input rob_idx_t entry, input rob_idx_t redir);
        if (entry.wrap == redir.wrap) begin
            return entry.pos < redir.pos;
        end
        return entry.pos > redir.pos;
    endfunction

    // Any enabled broadcast port writing the given register
    function automatic logic preg_woken(
        input logic [WAKEUP_PORTS-1:0]             en,
        input logic [WAKEUP_PORTS-1:0][PREG_W-1:0] preg,
        input logic [PREG_W-1:0]                   tag
    );
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WAKEUP_PORTS; p++) begin
            hit = hit | (en[p] && (preg[p] == tag));
        end
        return hit;
    endfunction

endpackage

//--- design/store_issue_queue.sv
module store_issue_queue
    import store_iq_cfg_pkg::*;
    import store_iq_types_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                dis_en_i,
    input  rob_idx_t                            dis_rob_idx_i,
    input  logic [SQ_W-1:0]                     dis_sq_idx_i,
    input  mem_op_e                             dis_memop_i,
    input  logic [IMM_W-1:0]                    dis_imm_i,
    input  logic [PREG_W-1:0]                   dis_rs1_i,
    input  logic                                dis_rs1_ready_i,
    input  logic [PREG_W-1:0]                   dis_rs2_i,
    input  logic                                dis_rs2_ready_i,
    output logic                                full_o,
    input  logic [WAKEUP_PORTS-1:0]             wakeup_en_i,
    input  logic [WAKEUP_PORTS-1:0][PREG_W-1:0] wakeup_preg_i,
    input  logic                                redirect_i,
    input  rob_idx_t                            redirect_rob_idx_i,
    input  logic                                success_i,
    input  logic [ENTRY_W-1:0]                  success_entry_i,
    input  logic                                replay_i,
    input  logic [ENTRY_W-1:0]                  replay_entry_i,
    output logic                                addr_issue_o,
    output logic [ENTRY_W-1:0]                  addr_entry_o,
    output logic [PREG_W-1:0]                   addr_rs1_o,
    output logic [IMM_W-1:0]                    addr_imm_o,
    output size_code_t                          addr_size_o,
    output logic [SQ_W-1:0]                     addr_sq_idx_o,
    output rob_idx_t                            addr_rob_idx_o,
    output logic                                data_issue_o,
    output logic [PREG_W-1:0]                   data_rs2_o,
    output logic [SQ_W-1:0]                     data_sq_idx_o,
    output size_code_t                          data_size_o
);

    logic       addr_full;
    logic       data_full;
    logic       dis_fire;
    size_code_t dis_size;

    // Both halves must find room, so one full bank stalls dispatch
    assign full_o   = addr_full | data_full;
    assign dis_fire = dis_en_i & ~full_o;

    always_comb begin
        case (dis_memop_i)
            MEM_SB:  dis_size = SIZE_BYTE;
            MEM_SH:  dis_size = SIZE_HALF;
            MEM_SW:  dis_size = SIZE_WORD;
            default: dis_size = SIZE_BYTE;
        endcase
    end

    store_addr_bank u_addr_bank (
        .clk                (clk),
        .rst                (rst),
        .alloc_i            (dis_fire),
        .alloc_rob_idx_i    (dis_rob_idx_i),
        .alloc_sq_idx_i     (dis_sq_idx_i),
        .alloc_size_i       (dis_size),
        .alloc_imm_i        (dis_imm_i),
        .alloc_rs1_i        (dis_rs1_i),
        .alloc_rs1_ready_i  (dis_rs1_ready_i),
        .wakeup_en_i        (wakeup_en_i),
        .wakeup_preg_i      (wakeup_preg_i),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .success_i          (success_i),
        .success_entry_i    (success_entry_i),
        .replay_i           (replay_i),
        .replay_entry_i     (replay_entry_i),
        .full_o             (addr_full),
        .issue_o            (addr_issue_o),
        .issue_entry_o      (addr_entry_o),
        .issue_rs1_o        (addr_rs1_o),
        .issue_imm_o        (addr_imm_o),
        .issue_size_o       (addr_size_o),
        .issue_sq_idx_o     (addr_sq_idx_o),
        .issue_rob_idx_o    (addr_rob_idx_o)
    );

    store_data_bank u_data_bank (
        .clk                (clk),
        .rst                (rst),
        .alloc_i            (dis_fire),
        .alloc_rob_idx_i    (dis_rob_idx_i),
        .alloc_sq_idx_i     (dis_sq_idx_i),
        .alloc_size_i       (dis_size),
        .alloc_rs2_i        (dis_rs2_i),
        .alloc_rs2_ready_i  (dis_rs2_ready_i),
        .wakeup_en_i        (wakeup_en_i),
        .wakeup_preg_i      (wakeup_preg_i),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .full_o             (data_full),
        .issue_o            (data_issue_o),
        .issue_rs2_o        (data_rs2_o),
        .issue_sq_idx_o     (data_sq_idx_o),
        .issue_size_o       (data_size_o)
    );

endmodule

//--- flist.f
design/store_iq_cfg_pkg.sv
design/store_iq_types_pkg.sv
design/age_selector.sv
design/store_addr_bank.sv
design/store_data_bank.sv
design/store_issue_queue.sv
test/store_iq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the store issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module store_iq_tb -Mdir obj_dir -o store_iq_sim -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/store_iq_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- test/store_iq_tb.sv
module store_iq_tb
    import store_iq_cfg_pkg::*;
    import store_iq_types_pkg::*;
();

    // The five tests take a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int ADDR_WORD_W    = PREG_W + IMM_W + 2 + SQ_W + ROB_W + 1;
    localparam int DATA_WORD_W    = PREG_W + 2 + SQ_W;

    typedef struct packed {
        rob_idx_t          rob;
        logic [SQ_W-1:0]   sq;
        mem_op_e           op;
        logic [IMM_W-1:0]  imm;
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rs2;
    } store_t;

    logic                                clk;
    logic                                rst;
    logic                                dis_en_i;
    rob_idx_t                            dis_rob_idx_i;
    logic [SQ_W-1:0]                     dis_sq_idx_i;
    mem_op_e                             dis_memop_i;
    logic [IMM_W-1:0]                    dis_imm_i;
    logic [PREG_W-1:0]                   dis_rs1_i;
    logic                                dis_rs1_ready_i;
    logic [PREG_W-1:0]                   dis_rs2_i;
    logic                                dis_rs2_ready_i;
    logic                                full_o;
    logic [WAKEUP_PORTS-1:0]             wakeup_en_i;
    logic [WAKEUP_PORTS-1:0][PREG_W-1:0] wakeup_preg_i;
    logic                                redirect_i;
    rob_idx_t                            redirect_rob_idx_i;
    logic                                success_i;
    logic [ENTRY_W-1:0]                  success_entry_i;
    logic                                replay_i;
    logic [ENTRY_W-1:0]                  replay_entry_i;
    logic                                addr_issue_o;
    logic [ENTRY_W-1:0]                  addr_entry_o;
    logic [PREG_W-1:0]                   addr_rs1_o;
    logic [IMM_W-1:0]                    addr_imm_o;
    size_code_t                          addr_size_o;
    logic [SQ_W-1:0]                     addr_sq_idx_o;
    rob_idx_t                            addr_rob_idx_o;
    logic                                data_issue_o;
    logic [PREG_W-1:0]                   data_rs2_o;
    logic [SQ_W-1:0]                     data_sq_idx_o;
    size_code_t                          data_size_o;

    // Reference model state
    store_t                 exp_addr_q [$];
    store_t                 exp_data_q [$];
    logic [ENTRY_W-1:0]     resident_q [$];
    store_t                 entry_store [BANK_SIZE];
    store_t                 addr_head;
    store_t                 data_head;
    logic                   addr_expected = 1'b0;
    logic                   data_expected = 1'b0;
    logic [ADDR_WORD_W-1:0] exp_addr_word = '0;
    logic [DATA_WORD_W-1:0] exp_data_word = '0;
    logic [ADDR_WORD_W-1:0] act_addr_word;
    logic [DATA_WORD_W-1:0] act_data_word;
    logic [15:0]            lfsr;
    logic [ROB_W:0]         rob_count;
    int                     cycles = 0;
    string                  test_name;

    store_issue_queue DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("=== FAIL ===");
            $fatal(1, "timeout after %0d cycles while running %s", cycles, test_name);
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    // Byte, half and word stores map to size codes 0, 1 and 2
    function automatic logic [1:0] expected_size(input mem_op_e op);
        case (op)
            MEM_SH:  return 2'd1;
            MEM_SW:  return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    // A store survives a redirect only when it is strictly older
    function automatic logic survives(input rob_idx_t e, input rob_idx_t r);
        if (e.wrap != r.wrap) begin
            return e.pos > r.pos;
        end
        return e.pos < r.pos;
    endfunction

    task automatic make_store(input mem_op_e op, output store_t s);
        logic [15:0] v;
        s.op      = op;
        s.rob     = rob_count;
        rob_count = rob_count + 1'b1;
        take_bits(SQ_W, v);
        s.sq = v[SQ_W-1:0];
        take_bits(IMM_W, v);
        s.imm = v[IMM_W-1:0];
        take_bits(PREG_W, v);
        s.rs1 = v[PREG_W-1:0];
        take_bits(PREG_W, v);
        s.rs2 = v[PREG_W-1:0];
    endtask

    task automatic clear_strobes();
        dis_en_i    = 1'b0;
        wakeup_en_i = '0;
        redirect_i  = 1'b0;
        success_i   = 1'b0;
        replay_i    = 1'b0;
    endtask

    task automatic settle();
        @(negedge clk);
        clear_strobes();
    endtask

    task automatic dispatch_store(input store_t s, input logic rs1_rdy, input logic rs2_rdy);
        @(negedge clk);
        clear_strobes();
        while (full_o) begin
            @(negedge clk);
        end
        dis_en_i        = 1'b1;
        dis_rob_idx_i   = s.rob;
        dis_sq_idx_i    = s.sq;
        dis_memop_i     = s.op;
        dis_imm_i       = s.imm;
        dis_rs1_i       = s.rs1;
        dis_rs1_ready_i = rs1_rdy;
        dis_rs2_i       = s.rs2;
        dis_rs2_ready_i = rs2_rdy;
        if (rs1_rdy) begin
            exp_addr_q.push_back(s);
        end
        if (rs2_rdy) begin
            exp_data_q.push_back(s);
        end
    endtask

    task automatic wake(input logic [PREG_W-1:0] rs1, input logic [PREG_W-1:0] rs2);
        @(negedge clk);
        clear_strobes();
        wakeup_en_i      = '1;
        wakeup_preg_i[1] = rs1;
        wakeup_preg_i[0] = rs2;
    endtask

    task automatic wait_idle();
        while (exp_addr_q.size() != 0 || exp_data_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Issued address entries stay resident until the memory pipe frees them
    task automatic drain_resident();
        while (resident_q.size() != 0) begin
            @(negedge clk);
            clear_strobes();
            success_i       = 1'b1;
            success_entry_i = resident_q.pop_front();
        end
        settle();
    endtask

    task automatic check_full(input logic expected);
        @(negedge clk);
        assert (full_o == expected)
            else begin
                $display("=== FAIL ===");
                $fatal(1, "mismatch %s full_o expected %0b actual %0b",
                       test_name, expected, full_o);
            end
    endtask

    // ----------------------------------------
    // Issue monitor and checks
    // ----------------------------------------

    assign act_addr_word = {addr_rs1_o, addr_imm_o, addr_size_o, addr_sq_idx_o, addr_rob_idx_o};
    assign act_data_word = {data_rs2_o, data_size_o, data_sq_idx_o};

    // The model advances at the falling edge and the assertions sample at the next rise
    always @(negedge clk) begin
        if (!rst && addr_issue_o) begin
            addr_expected = exp_addr_q.size() != 0;
            if (addr_expected) begin
                addr_head     = exp_addr_q.pop_front();
                exp_addr_word = {addr_head.rs1, addr_head.imm, expected_size(addr_head.op),
                                 addr_head.sq, addr_head.rob};
                entry_store[addr_entry_o] = addr_head;
            end
            resident_q.push_back(addr_entry_o);
        end
        if (!rst && data_issue_o) begin
            data_expected = exp_data_q.size() != 0;
            if (data_expected) begin
                data_head     = exp_data_q.pop_front();
                exp_data_word = {data_head.rs2, expected_size(data_head.op), data_head.sq};
            end
        end
    end

    addr_known: assert property (@(posedge clk) disable iff (rst) addr_issue_o |-> addr_expected)
        else begin
            $display("=== FAIL ===");
            $fatal(1, "%s: address issue when no store was ready to issue", test_name);
        end

    data_known: assert property (@(posedge clk) disable iff (rst) data_issue_o |-> data_expected)
        else begin
            $display("=== FAIL ===");
            $fatal(1, "%s: data issue when no store was ready to issue", test_name);
        end

    addr_payload: assert property (@(posedge clk) disable iff (rst)
        (addr_issue_o && addr_expected) |-> (act_addr_word == exp_addr_word))
        else begin
            $display("=== FAIL ===");
            $fatal(1, "mismatch %s address issue expected %h actual %h", test_name,
                   $sampled(exp_addr_word), $sampled(act_addr_word));
        end

    data_payload: assert property (@(posedge clk) disable iff (rst)
        (data_issue_o && data_expected) |-> (act_data_word == exp_data_word))
        else begin
            $display("=== FAIL ===");
            $fatal(1, "mismatch %s data issue expected %h actual %h", test_name,
                   $sampled(exp_data_word), $sampled(act_data_word));
        end

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    initial begin
        store_t             s;
        store_t             group [5];
        logic [15:0]        v;
        logic [PREG_W-1:0]  reg_a;
        logic [PREG_W-1:0]  reg_b;
        logic [ENTRY_W-1:0] e;

        lfsr               = 16'd5;
        // Starts near the end of the window so the redirect test crosses a wrap
        rob_count          = 6'd13;
        test_name          = "reset";
        rst                = 1'b1;
        dis_rob_idx_i      = '0;
        dis_sq_idx_i       = '0;
        dis_memop_i        = MEM_SB;
        dis_imm_i          = '0;
        dis_rs1_i          = '0;
        dis_rs1_ready_i    = 1'b0;
        dis_rs2_i          = '0;
        dis_rs2_ready_i    = 1'b0;
        wakeup_preg_i      = '0;
        redirect_rob_idx_i = '0;
        success_entry_i    = '0;
        replay_entry_i     = '0;
        clear_strobes();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "ready_store";
        make_store(MEM_SB, s);
        dispatch_store(s, 1'b1, 1'b1);
        make_store(MEM_SH, s);
        dispatch_store(s, 1'b1, 1'b1);
        make_store(MEM_SW, s);
        dispatch_store(s, 1'b1, 1'b1);
        settle();
        wait_idle();
        drain_resident();

        test_name = "wakeup";
        make_store(MEM_SW, s);
        dispatch_store(s, 1'b0, 1'b0);
        settle();
        repeat (20) @(posedge clk);
        exp_addr_q.push_back(s);
        exp_data_q.push_back(s);
        wake(s.rs1, s.rs2);
        settle();
        wait_idle();
        drain_resident();

        test_name = "oldest_first";
        take_bits(PREG_W, v);
        reg_a = v[PREG_W-1:0];
        take_bits(PREG_W, v);
        reg_b = v[PREG_W-1:0];
        // A ready store holds entry 0 while the first two arrive and frees it
        // before the rest, so dispatch order differs from entry order
        make_store(MEM_SW, s);
        dispatch_store(s, 1'b1, 1'b1);
        for (int i = 0; i < 4; i++) begin
            make_store(mem_op_e'(2'(i % 3)), group[i]);
            group[i].rs1 = reg_a;
            group[i].rs2 = reg_b;
            dispatch_store(group[i], 1'b0, 1'b0);
            if (i == 1) begin
                settle();
                wait_idle();
                drain_resident();
            end
        end
        settle();
        for (int i = 0; i < 4; i++) begin
            exp_addr_q.push_back(group[i]);
            exp_data_q.push_back(group[i]);
        end
        wake(reg_a, reg_b);
        settle();
        wait_idle();
        drain_resident();

        test_name = "occupancy";
        for (int i = 0; i < BANK_SIZE; i++) begin
            make_store(mem_op_e'(2'(i % 3)), s);
            dispatch_store(s, 1'b1, 1'b1);
        end
        settle();
        wait_idle();
        check_full(1'b1);
        e = resident_q.pop_front();
        exp_addr_q.push_back(entry_store[e]);
        @(negedge clk);
        clear_strobes();
        replay_i       = 1'b1;
        replay_entry_i = e;
        settle();
        wait_idle();
        e = resident_q.pop_front();
        @(negedge clk);
        clear_strobes();
        success_i       = 1'b1;
        success_entry_i = e;
        settle();
        check_full(1'b0);
        make_store(MEM_SH, s);
        dispatch_store(s, 1'b1, 1'b1);
        settle();
        wait_idle();
        check_full(1'b1);
        drain_resident();

        test_name = "redirect";
        take_bits(PREG_W, v);
        reg_a = v[PREG_W-1:0];
        take_bits(PREG_W, v);
        reg_b = v[PREG_W-1:0];
        for (int i = 0; i < 5; i++) begin
            make_store(mem_op_e'(2'(i % 3)), group[i]);
            group[i].rs1 = reg_a;
            group[i].rs2 = reg_b;
            dispatch_store(group[i], 1'b0, 1'b0);
        end
        @(negedge clk);
        clear_strobes();
        redirect_i         = 1'b1;
        redirect_rob_idx_i = group[2].rob;
        settle();
        for (int i = 0; i < 5; i++) begin
            if (survives(group[i].rob, group[2].rob)) begin
                exp_addr_q.push_back(group[i]);
                exp_data_q.push_back(group[i]);
            end
        end
        wake(reg_a, reg_b);
        settle();
        wait_idle();
        // Any flushed store that still issues shows up as an unexpected issue here
        repeat (12) @(posedge clk);
        drain_resident();

        repeat (4) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule
